//--- rtl/la_capture.sv
`timescale 1ns/100ps

module la_capture import la_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [SAMPLE_W-1:0] pins_i,
    input  la_cfg_t             cfg_i,
    input  logic                arm_i,
    output logic                wr_en_o,
    output logic [ADDR_W-1:0]   wr_addr_o,
    output logic [SAMPLE_W-1:0] wr_data_o,
    output logic                done_o,
    output logic [ADDR_W-1:0]   wptr_o
);

    logic [SAMPLE_W-1:0] pin_q;                         // newest latch
    logic [SAMPLE_W-1:0] pin_qq;                        // previous latch
    logic                running;
    logic                triggered;
    logic [7:0]          presc_cnt;
    logic [7:0]          post_cnt;
    logic [ADDR_W-1:0]   ptr;
    logic                trig_event;
    logic                tick;

    // a masked pin moved and a masked pin sits at its polarity
    assign trig_event = (|((pin_q ^ pin_qq) & cfg_i.mask)) &
                        (|(~(pin_q ^ cfg_i.pol) & cfg_i.mask));

    assign tick      = running && (presc_cnt == cfg_i.prescale);
    assign wr_en_o   = tick && (post_cnt != '0);        // last tick only stops
    assign wr_addr_o = ptr;
    assign wr_data_o = pin_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_q     <= '0;
            pin_qq    <= '0;
            running   <= 1'b0;
            triggered <= 1'b0;
            presc_cnt <= '0;
            post_cnt  <= '0;
            ptr       <= '0;
            done_o    <= 1'b0;
            wptr_o    <= '0;
        end else begin
            pin_q  <= pins_i;
            pin_qq <= pin_q;
            done_o <= 1'b0;
            if (arm_i) begin
                ptr       <= '0;
                presc_cnt <= '0;
                triggered <= 1'b0;
                post_cnt  <= cfg_i.post;
                if (cfg_i.post == '0) begin
                    done_o <= 1'b1;                     // nothing to capture
                    wptr_o <= '0;
                end else begin
                    running <= 1'b1;
                end
            end else if (running) begin
                if (trig_event) begin
                    triggered <= 1'b1;
                end
                if (tick) begin
                    presc_cnt <= '0;
                    if (post_cnt == '0) begin
                        running <= 1'b0;
                        done_o  <= 1'b1;
                        wptr_o  <= ptr;                 // oldest sample
                    end else begin
                        ptr <= ptr + 1'b1;
                        if (triggered) begin
                            post_cnt <= post_cnt - 1'b1;
                        end
                    end
                end else begin
                    presc_cnt <= presc_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/la_frame_regs.sv
`timescale 1ns/100ps

module la_frame_regs import la_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  byte_stb_t rx_i,
    input  logic      idle_i,
    output la_cfg_t   cfg_o,
    output logic      arm_o,
    output logic      busy_o
);

    la_frame_u                      frame_q;
    la_frame_u                      frame_next;
    logic [$clog2(FRAME_BYTES)-1:0] idx;                // next byte slot
    logic                           idle_d;

    // frame as it looks with the incoming byte merged in
    always_comb begin
        frame_next            = frame_q;
        frame_next.bytes[idx] = rx_i.data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx    <= '0;
            arm_o  <= 1'b0;
            busy_o <= 1'b0;
            idle_d <= 1'b1;
        end else begin
            arm_o  <= 1'b0;
            idle_d <= idle_i;
            if (idle_i && !idle_d) begin
                busy_o <= 1'b0;                         // readout finished
            end
            if (rx_i.stb && !busy_o) begin
                frame_q <= frame_next;
                idx     <= idx + 1'b1;                  // wraps after the last byte
                if (idx == FRAME_BYTES - 1) begin
                    arm_o  <= 1'b1;
                    busy_o <= 1'b1;
                end
            end
        end
    end

    // config only changes when a full command lands
    always_ff @(posedge clk) begin
        if (rx_i.stb && !busy_o && idx == FRAME_BYTES - 1) begin
            cfg_o <= frame_next.cfg;
        end
    end

endmodule

//--- rtl/la_pkg.sv
package la_pkg;

    localparam int SAMPLE_W     = 8;
    localparam int ADDR_W       = 8;                    // 256 entry ring
    localparam int CLKS_PER_BIT = 16;                   // short baud for simulation
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BYTES  = 4;

    // byte 0 of the command sits at the low end of the word
    typedef struct packed {
        logic [7:0] post;                               // byte 3
        logic [7:0] prescale;                           // byte 2
        logic [7:0] pol;                                // byte 1
        logic [7:0] mask;                               // byte 0
    } la_cfg_t;

    typedef union packed {
        logic [FRAME_BYTES-1:0][7:0] bytes;             // view while assembling
        la_cfg_t                     cfg;               // view once complete
    } la_frame_u;

    typedef struct packed {
        logic       stb;
        logic [7:0] data;
    } byte_stb_t;

endpackage

//--- rtl/la_readout.sv
`timescale 1ns/100ps

module la_readout import la_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                done_i,
    input  logic [ADDR_W-1:0]   wptr_i,
    input  logic                tx_busy_i,
    output logic [ADDR_W-1:0]   rd_addr_o,
    input  logic [SAMPLE_W-1:0] rd_data_i,
    output byte_stb_t           tx_o,
    output logic                idle_o
);

    typedef enum logic [2:0] {S_IDLE, S_WAIT, S_SENT, S_READ, S_LATCH} rd_state_e;
    typedef enum logic [1:0] {PH_LO, PH_HI, PH_BUF} rd_phase_e;

    rd_state_e         state;
    rd_phase_e         phase;                           // what was last queued
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        data_q;

    assign rd_addr_o = addr_q;
    assign idle_o    = (state == S_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            phase  <= PH_LO;
            addr_q <= '0;
            tx_o   <= '0;
        end else begin
            tx_o.stb <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (done_i) begin
                        data_q <= wptr_i;               // low byte of pointer
                        phase  <= PH_LO;
                        state  <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (!tx_busy_i) begin
                        tx_o.stb  <= 1'b1;
                        tx_o.data <= data_q;
                        state     <= S_SENT;            // tx busy not up yet
                    end
                end
                S_SENT: begin
                    case (phase)
                        PH_LO: begin
                            data_q <= 8'h00;            // high byte is zero for a 256 deep ring
                            phase  <= PH_HI;
                            state  <= S_WAIT;
                        end
                        PH_HI: begin
                            addr_q <= '0;
                            phase  <= PH_BUF;
                            state  <= S_READ;
                        end
                        default: begin
                            if (addr_q == '1) begin
                                state <= S_IDLE;        // 258th byte queued
                            end else begin
                                addr_q <= addr_q + 1'b1;
                                state  <= S_READ;
                            end
                        end
                    endcase
                end
                S_READ: state <= S_LATCH;               // ram latency
                default: begin
                    data_q <= rd_data_i;
                    state  <= S_WAIT;
                end
            endcase
        end
    end

endmodule

//--- rtl/la_sample_ram.sv
`timescale 1ns/100ps

module la_sample_ram import la_pkg::*; (
    input  logic                clk,
    input  logic                wr_en_i,
    input  logic [ADDR_W-1:0]   wr_addr_i,
    input  logic [SAMPLE_W-1:0] wr_data_i,
    input  logic [ADDR_W-1:0]   rd_addr_i,
    output logic [SAMPLE_W-1:0] rd_data_o
);

    logic [SAMPLE_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- rtl/logic_analyzer_top.sv
`timescale 1ns/100ps

module logic_analyzer_top import la_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [SAMPLE_W-1:0] pins_i,
    input  logic                uart_rx_i,
    output logic                uart_tx_o
);

    byte_stb_t           rx_byte;
    byte_stb_t           tx_byte;
    la_cfg_t             cfg;
    logic                arm;
    logic                wr_en;
    logic [ADDR_W-1:0]   wr_addr;
    logic [SAMPLE_W-1:0] wr_data;
    logic                cap_done;
    logic [ADDR_W-1:0]   wptr;
    logic [ADDR_W-1:0]   rd_addr;
    logic [SAMPLE_W-1:0] rd_data;
    logic                tx_busy;
    logic                rd_idle;

    uart_rx uart_rx_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_i   (uart_rx_i),
        .byte_o (rx_byte)
    );

    la_frame_regs la_frame_regs_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .rx_i   (rx_byte),
        .idle_i (rd_idle),
        .cfg_o  (cfg),
        .arm_o  (arm),
        .busy_o ()
    );

    la_capture la_capture_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pins_i    (pins_i),
        .cfg_i     (cfg),
        .arm_i     (arm),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data),
        .done_o    (cap_done),
        .wptr_o    (wptr)
    );

    la_sample_ram la_sample_ram_inst (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    la_readout la_readout_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .done_i    (cap_done),
        .wptr_i    (wptr),
        .tx_busy_i (tx_busy),
        .rd_addr_o (rd_addr),
        .rd_data_i (rd_data),
        .tx_o      (tx_byte),
        .idle_o    (rd_idle)
    );

    uart_tx uart_tx_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .byte_i (tx_byte),
        .tx_o   (uart_tx_o),
        .busy_o (tx_busy)
    );

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/100ps

module uart_rx import la_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rx_i,
    output byte_stb_t byte_o
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e             state;
    logic [1:0]            sync_q;                      // two flop synchronizer
    logic [BAUD_CNT_W-1:0] cnt;
    logic [2:0]            bit_idx;
    logic [7:0]            shreg;
    logic                  rx_s;

    assign rx_s = sync_q[1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q  <= 2'b11;                           // line idles high
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            byte_o  <= '0;
        end else begin
            sync_q     <= {sync_q[0], rx_i};
            byte_o.stb <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s) begin
                        state <= RX_START;              // falling edge of start bit
                    end
                end
                RX_START: begin
                    if (cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;    // glitch check
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
                        cnt     <= '0;
                        shreg   <= {rx_s, shreg[7:1]};  // lsb first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
                        state <= RX_IDLE;
                        if (rx_s) begin                 // framing error drops the byte
                            byte_o.stb  <= 1'b1;
                            byte_o.data <= shreg;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/100ps

module uart_tx import la_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  byte_stb_t byte_i,
    output logic      tx_o,
    output logic      busy_o
);

    logic [BAUD_CNT_W-1:0] cnt;
    logic [3:0]            bit_cnt;                     // 0 is the start bit
    logic [8:0]            shreg;                       // data plus stop bit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_o    <= 1'b1;
            busy_o  <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (!busy_o) begin
            if (byte_i.stb) begin
                shreg   <= {1'b1, byte_i.data};
                tx_o    <= 1'b0;                        // start bit
                busy_o  <= 1'b1;
                cnt     <= '0;
                bit_cnt <= '0;
            end
        end else if (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
            cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy_o <= 1'b0;                         // stop bit done
            end else begin
                tx_o    <= shreg[0];
                shreg   <= {1'b1, shreg[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the logic analyzer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_logic_analyzer
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f vlog.f -o "V$TOP"

./obj_dir/V"$TOP" | tee "$LOG"

if grep -qF '*** TEST FAILED ***' "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"

//--- sim/tb_logic_analyzer.sv
`timescale 1ns/100ps

module tb_logic_analyzer import la_pkg::*; ();

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 10;
    localparam int REPLY_BYTES   = 2 + 2**ADDR_W;       // pointer bytes then buffer
    localparam int BYTE_LIMIT    = 20 * CLKS_PER_BIT;   // two frame times
    localparam int CAPTURE_LIMIT = 1000;
    localparam int FILL_CYCLES   = 1200;                // over 256 ticks at prescale 3
    // five dumps of about 42k cycles plus capture and idle waits
    localparam int MAX_CYCLES    = 400000;
    localparam logic [15:0] LFSR_SEED = 16'd37155;

    logic        clk;
    logic        rst_n;
    logic [7:0]  pins;
    logic        uart_rx;
    logic        uart_tx;
    logic [15:0] lfsr_q;
    int unsigned cycle_cnt = 0;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [7:0]  reply [REPLY_BYTES];
    int          reply_len;

    logic_analyzer_top logic_analyzer_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pins_i    (pins),
        .uart_rx_i (uart_rx),
        .uart_tx_o (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("run aborted, cycle limit of %0d reached", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic send_byte(input logic [7:0] data);
        uart_rx = 1'b0;                                 // start bit
        wait_cycles(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            uart_rx = data[i];
            wait_cycles(CLKS_PER_BIT);
        end
        uart_rx = 1'b1;                                 // stop bit
        wait_cycles(CLKS_PER_BIT);
    endtask

    task automatic recv_byte(input int limit, output logic [7:0] data, output logic ok);
        int waited;
        waited = 0;
        data   = '0;
        while (uart_tx === 1'b1 && waited < limit) begin
            wait_cycles(1);
            waited++;
        end
        ok = (uart_tx === 1'b0);
        assert (ok) else begin
            $display("no start bit on uart_tx_o within %0d cycles", limit);
            errors++;
        end
        if (ok) begin
            wait_cycles(CLKS_PER_BIT / 2);              // middle of start bit
            for (int i = 0; i < 8; i++) begin
                wait_cycles(CLKS_PER_BIT);
                data[i] = uart_tx;
            end
            wait_cycles(CLKS_PER_BIT);
            assert (uart_tx === 1'b1) else begin
                $display("stop bit on uart_tx_o is not high");
                errors++;
            end
        end
    endtask

    task automatic recv_reply(input int first_limit);
        logic [7:0] b;
        logic       ok;
        int         limit;
        reply_len = 0;
        ok        = 1'b1;
        limit     = first_limit;
        while (ok && reply_len < REPLY_BYTES) begin
            recv_byte(limit, b, ok);
            if (ok) begin
                reply[reply_len] = b;
                reply_len++;
            end
            limit = BYTE_LIMIT;
        end
    endtask

    task automatic send_command(input logic [7:0] mask, input logic [7:0] pol,
                                input logic [7:0] presc, input logic [7:0] post,
                                input logic gaps);
        logic [7:0] cmd [FRAME_BYTES];
        cmd = '{mask, pol, presc, post};
        for (int i = 0; i < FRAME_BYTES; i++) begin
            if (gaps) begin
                wait_cycles(take_bits(6));              // idle gap of 0 to 63 cycles
            end
            send_byte(cmd[i]);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s expected 0x%02h got 0x%02h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_line_quiet(input int n, input string what);
        logic seen_low;
        seen_low = 1'b0;
        for (int i = 0; i < n; i++) begin
            wait_cycles(1);
            if (uart_tx !== 1'b1) seen_low = 1'b1;
        end
        assert (!seen_low) else begin
            $display("unexpected activity on uart_tx_o during %s", what);
            errors++;
        end
    endtask

    // newest 15 samples before wptr are high, the oldest at wptr is low
    task automatic check_ring();
        logic [7:0] wptr;
        logic [7:0] addr;
        logic [7:0] b;
        assert (reply_len == REPLY_BYTES) else begin
            $display("reply has %0d bytes instead of %0d", reply_len, REPLY_BYTES);
            errors++;
        end
        if (reply_len == REPLY_BYTES) begin
            wptr = reply[0];
            check_byte("wptr_hi", 8'h00, reply[1]);
            for (int a = 0; a < 2**ADDR_W; a++) begin
                b = reply[2 + a];
                assert (b === 8'h3C || b === 8'hBC) else begin
                    $display("[FAIL] buffer[%0d] expected 0x3c or 0xbc got 0x%02h", a, b);
                    errors++;
                end
            end
            for (int k = 1; k <= 15; k++) begin
                addr = wptr - 8'(k);
                check_byte($sformatf("buffer[%0d]", addr), 8'hBC, reply[2 + int'(addr)]);
            end
            check_byte($sformatf("buffer[%0d]", wptr), 8'h3C, reply[2 + int'(wptr)]);
        end
    endtask

    task automatic start_test();
        errors = 0;
    endtask

    task automatic finish_test(input string name);
        if (errors == 0) begin
            tests_passed++;
            $display("%-18s pass", name);
        end else begin
            tests_failed++;
            $display("%-18s fail with %0d errors", name, errors);
        end
    endtask

    task automatic idle_after_reset();
        start_test();
        check_line_quiet(2000, "idle after reset");
        finish_test("idle_after_reset");
    endtask

    task automatic post_zero_dump();
        start_test();
        send_command(8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
        recv_reply(CAPTURE_LIMIT);
        if (reply_len == REPLY_BYTES) begin
            check_byte("wptr_lo", 8'h00, reply[0]);
            check_byte("wptr_hi", 8'h00, reply[1]);
        end
        check_line_quiet(BYTE_LIMIT, "the gap after the reply");  // no 259th byte
        finish_test("post_zero_dump");
    endtask

    task automatic trigger_capture(input logic gaps);
        pins = 8'h3C;
        send_command(8'h80, 8'h80, 8'd3, 8'd16, gaps);
        wait_cycles(FILL_CYCLES);
        pins = 8'hBC;                                   // rising edge on bit 7
        recv_reply(CAPTURE_LIMIT);
        check_ring();
    endtask

    task automatic polarity_rule();
        start_test();
        pins = 8'hBC;
        send_command(8'h80, 8'h80, 8'd3, 8'd16, 1'b0);
        wait_cycles(FILL_CYCLES);
        pins = 8'h3C;                                   // falling edge must not trigger
        check_line_quiet(5000, "a falling edge on bit 7");
        pins = 8'hBC;
        recv_reply(CAPTURE_LIMIT);
        check_ring();
        finish_test("polarity_rule");
    endtask

    initial begin
        rst_n        = 1'b0;
        pins         = '0;
        uart_rx      = 1'b1;
        lfsr_q       = LFSR_SEED;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        wait_cycles(RESET_CYCLES);
        rst_n = 1'b1;

        idle_after_reset();
        post_zero_dump();
        start_test();
        trigger_capture(1'b0);
        finish_test("trigger_capture");
        polarity_rule();
        start_test();
        trigger_capture(1'b1);
        trigger_capture(1'b1);                          // starts right after the last readout
        finish_test("gapped_commands");

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/la_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/la_frame_regs.sv
rtl/la_capture.sv
rtl/la_sample_ram.sv
rtl/la_readout.sv
rtl/logic_analyzer_top.sv
sim/tb_logic_analyzer.sv
